// ==== Bender.yml ====
package:
  name: serial_display

sources:
  - files:
      - hdl/disp_pkg.sv
      - hdl/serial_pkg.sv
      - hdl/serial_tx.sv
      - hdl/frame_buffer.sv
      - hdl/video_serial.sv
      - hdl/serial_display.sv
  - target: test
    files:
      - testbench/tb_serial_display.sv

// ==== all.f ====
hdl/disp_pkg.sv
hdl/serial_pkg.sv
hdl/serial_tx.sv
hdl/frame_buffer.sv
hdl/video_serial.sv
hdl/serial_display.sv
testbench/tb_serial_display.sv

// ==== hdl/disp_pkg.sv ====
// display-side types shared by the frame buffer and the sequencer
// coordinates are 8 bits, so the screen is at most 256 by 256 pixels
// pixels are 16 bits, sent high byte first

package disp_pkg;

	// x or y position on the screen
	typedef logic [7:0] coord_t;

	// one 16 bit pixel, split into the two bytes sent on the link
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} pixel_t;

	// host write payload, valid together with the write strobe
	typedef struct packed {
		coord_t x;
		coord_t y;
		pixel_t pix;
	} fb_write_t;

	// sequencer FSM states
	typedef enum logic [2:0] {
		reset_wait,
		write_init,
		next_init,
		fetch,
		write_hi,
		write_lo,
		next_pixel,
		idle
	} ctrl_state_t;

endpackage

// ==== hdl/frame_buffer.sv ====
// pixel memory, row major, address = y * screen_width + x
// writes outside the screen are dropped, reads have one cycle latency
// after reset a clear pass zeroes every pixel the host has not written yet;
// it steps only in cycles without a host write, so it needs that many free cycles
`timescale 1ns/1ps

module frame_buffer #(
	parameter int screen_width = 8,
	parameter int screen_height = 4
) (
	input logic in_clk,
	input logic in_rst,
	input logic wr,
	input disp_pkg::fb_write_t wdata,
	input disp_pkg::coord_t rd_x,
	input disp_pkg::coord_t rd_y,
	output disp_pkg::pixel_t rd_pix
);

	localparam int depth = screen_width * screen_height;
	localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;

	disp_pkg::pixel_t mem [depth];
	logic [depth-1:0] dirty;
	logic [addr_w-1:0] clr_cnt;
	logic clearing;
	logic host_we;
	logic clr_we;
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;

	assign host_we = wr && (int'(wdata.x) < screen_width) && (int'(wdata.y) < screen_height);
	assign wr_addr = addr_w'(int'(wdata.y) * screen_width + int'(wdata.x));
	assign rd_addr = addr_w'(int'(rd_y) * screen_width + int'(rd_x));
	// host data already in place must survive the clear pass
	assign clr_we = clearing && !host_we && !dirty[clr_cnt];

	always_ff @(posedge in_clk) begin
		if (host_we) begin
			mem[wr_addr] <= wdata.pix;
		end else if (clr_we) begin
			mem[clr_cnt] <= '0;
		end
		rd_pix <= mem[rd_addr];
	end

	// clear counter
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			clearing <= 1'b1;
			clr_cnt <= '0;
			dirty <= '0;
		end else begin
			if (host_we) begin
				dirty[wr_addr] <= 1'b1;
			end
			if (clearing && !host_we) begin
				if (clr_cnt == addr_w'(depth - 1)) begin
					clearing <= 1'b0;
				end else begin
					clr_cnt <= clr_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/serial_display.sv ====
// serial pixel display controller, everything on in_clk
// host writes pixels with a one cycle strobe, start resends the frame
// out_busy is high from reset until the last byte of a frame is out
`timescale 1ns/1ps

module serial_display #(
	parameter int screen_width = 8,
	parameter int screen_height = 4,
	parameter int clk_div = 4,
	parameter int reset_wait = 40
) (
	input logic in_clk,
	input logic in_rst,
	input logic in_wr,
	input disp_pkg::fb_write_t in_wdata,
	input logic in_start,
	output serial_pkg::ser_line_t out_line,
	output logic out_busy
);

	disp_pkg::coord_t rd_x;
	disp_pkg::coord_t rd_y;
	disp_pkg::pixel_t rd_pix;
	serial_pkg::ser_word_t tx_data;
	logic tx_enable;
	logic word_done;
	logic vid_rst;
	logic sclk;
	logic sdata;

	frame_buffer #(
		.screen_width(screen_width),
		.screen_height(screen_height)
	) frame_buffer_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.wr(in_wr),
		.wdata(in_wdata),
		.rd_x(rd_x),
		.rd_y(rd_y),
		.rd_pix(rd_pix)
	);

	video_serial #(
		.screen_width(screen_width),
		.screen_height(screen_height),
		.reset_wait(reset_wait)
	) video_serial_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.start(in_start),
		.rd_pix(rd_pix),
		.rd_x(rd_x),
		.rd_y(rd_y),
		.tx_enable(tx_enable),
		.tx_data(tx_data),
		.word_done(word_done),
		.vid_rst(vid_rst),
		.busy(out_busy)
	);

	serial_tx #(
		.clk_div(clk_div)
	) serial_tx_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.tx_enable(tx_enable),
		.tx_data(tx_data),
		.sclk(sclk),
		.sdata(sdata),
		.word_done(word_done)
	);

	// display pins
	assign out_line.vid_rst = vid_rst;
	assign out_line.sclk = sclk;
	assign out_line.sdata = sdata;

endmodule

// ==== hdl/serial_pkg.sv ====
// serial-link types for the display pins and the byte transmitter
// one word on the link is one byte

package serial_pkg;

	// one byte on the link
	typedef logic [7:0] ser_word_t;

	// display pins
	typedef struct packed {
		logic vid_rst;
		logic sclk;
		logic sdata;
	} ser_line_t;

	// transmitter FSM
	typedef enum logic {
		tx_idle,
		tx_shift
	} tx_state_t;

endpackage

// ==== hdl/serial_tx.sv ====
// byte transmitter, MSB first, sclk idles high and sdata idles low
// each sclk half period lasts clk_div cycles of in_clk, clk_div >= 1
// tx_data is taken when a byte starts; it is not loaded while word_done is high
// dropping tx_enable aborts the byte and returns the line to idle
`timescale 1ns/1ps

module serial_tx #(
	parameter int clk_div = 4
) (
	input logic in_clk,
	input logic in_rst,
	input logic tx_enable,
	input serial_pkg::ser_word_t tx_data,
	output logic sclk,
	output logic sdata,
	output logic word_done
);

	localparam int word_bits = $bits(serial_pkg::ser_word_t);
	localparam int bit_w = $clog2(word_bits);
	localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

	serial_pkg::tx_state_t state;
	serial_pkg::ser_word_t shreg;
	logic [div_w-1:0] div_cnt;
	logic [bit_w-1:0] bit_cnt;
	logic phase_hi;
	logic load;
	logic div_end;
	logic last_bit;

	// start a byte only once the controller had a cycle to update tx_data
	assign load = (state == serial_pkg::tx_idle) && tx_enable && !word_done;
	assign div_end = (div_cnt == div_w'(clk_div - 1));
	assign last_bit = (bit_cnt == bit_w'(word_bits - 1));

	// data is valid during the low phase and held through the rising edge
	assign sclk = (state == serial_pkg::tx_shift) ? phase_hi : 1'b1;
	assign sdata = (state == serial_pkg::tx_shift) ? shreg[word_bits-1] : 1'b0;

	// ----------------------------------------
	// bit timing
	// ----------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_pkg::tx_idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			phase_hi <= 1'b0;
			word_done <= 1'b0;
		end else begin
			word_done <= 1'b0;
			case (state)
				serial_pkg::tx_idle: begin
					if (load) begin
						state <= serial_pkg::tx_shift;
						div_cnt <= '0;
						bit_cnt <= '0;
						phase_hi <= 1'b0;
					end
				end
				serial_pkg::tx_shift: begin
					if (!tx_enable) begin
						state <= serial_pkg::tx_idle;
					end else if (div_end) begin
						div_cnt <= '0;
						phase_hi <= !phase_hi;
						// end of the high phase closes one bit
						if (phase_hi) begin
							if (last_bit) begin
								word_done <= 1'b1;
								state <= serial_pkg::tx_idle;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= serial_pkg::tx_idle;
			endcase
		end
	end

	// shift register, msb leaves first
	always_ff @(posedge in_clk) begin
		if (load) begin
			shreg <= tx_data;
		end else if (state == serial_pkg::tx_shift && div_end && phase_hi && !last_bit) begin
			shreg <= {shreg[word_bits-2:0], 1'b0};
		end
	end

endmodule

// ==== hdl/video_serial.sv ====
// display sequencer: reset wait, two init bytes, then the frame row major
// each pixel goes out as two bytes, high byte first
// start is only taken in idle, a strobe during a frame is dropped
// reset_wait must be at least 1
`timescale 1ns/1ps

module video_serial #(
	parameter int screen_width = 8,
	parameter int screen_height = 4,
	parameter int reset_wait = 40
) (
	input logic in_clk,
	input logic in_rst,
	input logic start,
	input disp_pkg::pixel_t rd_pix,
	output disp_pkg::coord_t rd_x,
	output disp_pkg::coord_t rd_y,
	output logic tx_enable,
	output serial_pkg::ser_word_t tx_data,
	input logic word_done,
	output logic vid_rst,
	output logic busy
);

	localparam int num_init = 2;
	localparam serial_pkg::ser_word_t init_bytes [num_init] = '{8'hff, 8'h00};
	localparam int init_w = (num_init > 1) ? $clog2(num_init) : 1;
	localparam int wait_w = $clog2(reset_wait + 1);

	disp_pkg::ctrl_state_t state;
	disp_pkg::ctrl_state_t state_next;
	logic [wait_w-1:0] wait_cnt;
	logic [wait_w-1:0] wait_next;
	logic [init_w-1:0] init_cnt;
	logic [init_w-1:0] init_next;
	disp_pkg::coord_t x_cnt;
	disp_pkg::coord_t x_next;
	disp_pkg::coord_t y_cnt;
	disp_pkg::coord_t y_next;
	disp_pkg::pixel_t pix_q;

	// read address runs one cycle ahead, so rd_pix is valid in fetch
	assign rd_x = x_next;
	assign rd_y = y_next;
	assign vid_rst = (state == disp_pkg::reset_wait);
	assign busy = (state != disp_pkg::idle);

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= disp_pkg::reset_wait;
			wait_cnt <= '0;
			init_cnt <= '0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			state <= state_next;
			wait_cnt <= wait_next;
			init_cnt <= init_next;
			x_cnt <= x_next;
			y_cnt <= y_next;
		end
	end

	// both bytes of a pixel come from this one read
	always_ff @(posedge in_clk) begin
		if (state == disp_pkg::fetch) begin
			pix_q <= rd_pix;
		end
	end

	always_comb begin
		state_next = state;
		wait_next = wait_cnt;
		init_next = init_cnt;
		x_next = x_cnt;
		y_next = y_cnt;
		tx_enable = 1'b0;
		tx_data = '0;

		case (state)
			disp_pkg::reset_wait: begin
				if (wait_cnt == wait_w'(reset_wait - 1)) begin
					state_next = disp_pkg::write_init;
				end else begin
					wait_next = wait_cnt + 1'b1;
				end
			end

			// ----------------------------------------
			// init bytes
			// ----------------------------------------
			disp_pkg::write_init: begin
				tx_enable = 1'b1;
				tx_data = init_bytes[init_cnt];
				if (word_done) begin
					state_next = disp_pkg::next_init;
				end
			end
			disp_pkg::next_init: begin
				if (init_cnt == init_w'(num_init - 1)) begin
					x_next = '0;
					y_next = '0;
					state_next = disp_pkg::fetch;
				end else begin
					init_next = init_cnt + 1'b1;
					state_next = disp_pkg::write_init;
				end
			end

			// ----------------------------------------
			// pixel stream
			// ----------------------------------------
			disp_pkg::fetch: begin
				state_next = disp_pkg::write_hi;
			end
			disp_pkg::write_hi: begin
				tx_enable = 1'b1;
				tx_data = pix_q.hi;
				if (word_done) begin
					state_next = disp_pkg::write_lo;
				end
			end
			disp_pkg::write_lo: begin
				tx_enable = 1'b1;
				tx_data = pix_q.lo;
				if (word_done) begin
					state_next = disp_pkg::next_pixel;
				end
			end
			disp_pkg::next_pixel: begin
				state_next = disp_pkg::fetch;
				if (x_cnt == disp_pkg::coord_t'(screen_width - 1)) begin
					x_next = '0;
					if (y_cnt == disp_pkg::coord_t'(screen_height - 1)) begin
						y_next = '0;
						state_next = disp_pkg::idle;
					end else begin
						y_next = y_cnt + 8'd1;
					end
				end else begin
					x_next = x_cnt + 8'd1;
				end
			end

			// frame done, resend only on start
			disp_pkg::idle: begin
				if (start) begin
					x_next = '0;
					y_next = '0;
					state_next = disp_pkg::fetch;
				end
			end
			default: state_next = disp_pkg::idle;
		endcase
	end

endmodule

// ==== testbench/tb_serial_display.sv ====
// testbench for serial_display with random pixels from a 16 bit LFSR
// the serial line is decoded at rising sclk, sampled on falling in_clk
// the run stops at the first mismatch
`timescale 1ns/1ps

module tb_serial_display;

	localparam int screen_width = 8;
	localparam int screen_height = 4;
	localparam int clk_div = 4;
	localparam int reset_wait = 40;
	localparam int num_pix_bytes = 2 * screen_width * screen_height;
	localparam int frame_cycles = (2 + num_pix_bytes) * 16 * clk_div;
	localparam int timeout_limit = 2 * (reset_wait + 2 * frame_cycles);

	logic in_clk;
	logic in_rst;
	logic in_wr;
	disp_pkg::fb_write_t in_wdata;
	logic in_start;
	serial_pkg::ser_line_t out_line;
	logic out_busy;

	disp_pkg::pixel_t model [screen_height][screen_width];
	serial_pkg::ser_word_t rx_q [$];
	serial_pkg::ser_word_t rx_shift;
	int rx_total = 0;
	int rx_bits = 0;
	logic sclk_q = 1'b1;
	logic [15:0] lfsr;
	int cycle_cnt = 0;

	serial_display #(
		.screen_width(screen_width),
		.screen_height(screen_height),
		.clk_div(clk_div),
		.reset_wait(reset_wait)
	) serial_display_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.in_wr(in_wr),
		.in_wdata(in_wdata),
		.in_start(in_start),
		.out_line(out_line),
		.out_busy(out_busy)
	);

	initial begin
		in_clk = 1'b0;
		forever #4 in_clk = ~in_clk;
	end

	// ----------------------------------------
	// error reporting and random numbers
	// ----------------------------------------
	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	always @(posedge in_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			abort_run($sformatf("timeout: no result after %0d clock cycles", timeout_limit));
		end
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic check_byte(input serial_pkg::ser_word_t got,
			input serial_pkg::ser_word_t exp, input string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
		end
	endtask

	task automatic check_pixel(input disp_pkg::pixel_t got,
			input disp_pkg::pixel_t exp, input string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s: got %04h, expected %04h", what, got, exp));
		end
	endtask

	// ----------------------------------------
	// serial line monitor
	// ----------------------------------------
	always @(negedge in_clk) begin
		// line must rest while the display is in reset or the frame is done
		if (out_line.vid_rst === 1'b1 || out_busy === 1'b0) begin
			if (out_line.sclk !== 1'b1 || out_line.sdata !== 1'b0) begin
				report_mismatch("serial line not idle during display reset or idle");
			end
		end
		if (out_line.sclk === 1'b1 && sclk_q === 1'b0) begin
			rx_shift = {rx_shift[6:0], out_line.sdata};
			rx_bits = rx_bits + 1;
			if (rx_bits == 8) begin
				rx_q.push_back(rx_shift);
				rx_total = rx_total + 1;
				rx_bits = 0;
			end
		end
		sclk_q = out_line.sclk;
	end

	// ----------------------------------------
	// host side
	// ----------------------------------------
	task automatic host_write(input disp_pkg::fb_write_t w);
		@(posedge in_clk);
		in_wr <= 1'b1;
		in_wdata <= w;
	endtask

	task automatic pulse_start();
		@(posedge in_clk);
		in_start <= 1'b1;
		@(posedge in_clk);
		in_start <= 1'b0;
	endtask

	// every pixel gets a new random value, then two off-screen writes
	task automatic fill_frame();
		logic [15:0] r;
		logic [15:0] off;
		disp_pkg::fb_write_t w;
		for (int y = 0; y < screen_height; y++) begin
			for (int x = 0; x < screen_width; x++) begin
				take_bits(16, r);
				w.x = disp_pkg::coord_t'(x);
				w.y = disp_pkg::coord_t'(y);
				w.pix = r;
				model[y][x] = r;
				host_write(w);
			end
		end
		take_bits(8, off);
		take_bits(16, r);
		w.x = disp_pkg::coord_t'(screen_width + int'(off[3:0]));
		w.y = '0;
		w.pix = r;
		host_write(w);
		w.x = '0;
		w.y = disp_pkg::coord_t'(screen_height + int'(off[7:4]));
		host_write(w);
		@(posedge in_clk);
		in_wr <= 1'b0;
	endtask

	task automatic wait_bytes(input int n);
		while (rx_q.size() < n) begin
			@(negedge in_clk);
		end
	endtask

	task automatic wait_idle();
		while (out_busy !== 1'b0) begin
			@(negedge in_clk);
		end
	endtask

	task automatic check_frame(input string what);
		disp_pkg::pixel_t got;
		for (int y = 0; y < screen_height; y++) begin
			for (int x = 0; x < screen_width; x++) begin
				wait_bytes(2);
				got.hi = rx_q.pop_front();
				got.lo = rx_q.pop_front();
				check_pixel(got, model[y][x], $sformatf("%s x=%0d y=%0d", what, x, y));
			end
		end
		if (out_busy !== 1'b1) begin
			report_mismatch($sformatf("%s: out_busy low before the last byte", what));
		end
	endtask

	task automatic check_quiet(input int total);
		repeat (100) @(negedge in_clk);
		if (rx_total != total || out_busy !== 1'b0) begin
			report_mismatch($sformatf("%0d bytes sent, expected %0d, busy %b",
				rx_total, total, out_busy));
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		in_rst = 1'b1;
		in_wr = 1'b0;
		in_wdata = '0;
		in_start = 1'b0;
		lfsr = 16'd43;
		repeat (16) @(posedge in_clk);
		in_rst <= 1'b0;

		// first frame, written while the display is still in reset
		fill_frame();
		@(negedge in_clk);
		if (out_line.vid_rst !== 1'b1) begin
			abort_run("host writes did not finish before the display reset ended");
		end
		wait_bytes(2);
		check_byte(rx_q.pop_front(), 8'hff, "first init byte");
		check_byte(rx_q.pop_front(), 8'h00, "second init byte");
		check_frame("frame 1");
		wait_idle();
		check_quiet(2 + num_pix_bytes);

		// second frame, no init bytes, extra start mid frame is dropped
		fill_frame();
		pulse_start();
		wait_bytes(10);
		pulse_start();
		check_frame("frame 2");
		wait_idle();
		check_quiet(2 + 2 * num_pix_bytes);

		$display("Test completed successfully");
		$finish;
	end

endmodule
